// File: divsqrt_unit.f
source/divsqrt_cfg_pkg.sv
source/divsqrt_op_pkg.sv
source/divsqrt_pipe_reg.sv
source/divsqrt_decode.sv
source/divsqrt_ctrl.sv
source/divsqrt_iter_core.sv
source/divsqrt_result.sv
source/divsqrt_unit.sv
dv/divsqrt_unit_tb.sv

// File: Bender.yml
package:
  name: divsqrt_unit

sources:
  # Packages first, then the RTL in dependency order
  - source/divsqrt_cfg_pkg.sv
  - source/divsqrt_op_pkg.sv
  - source/divsqrt_pipe_reg.sv
  - source/divsqrt_decode.sv
  - source/divsqrt_ctrl.sv
  - source/divsqrt_iter_core.sv
  - source/divsqrt_result.sv
  - source/divsqrt_unit.sv
  - target: simulation
    files:
      - dv/divsqrt_unit_tb.sv

// File: dv/divsqrt_unit_tb.sv
`timescale 1ns/1ps

module divsqrt_unit_tb;

  import divsqrt_cfg_pkg::*;
  import divsqrt_op_pkg::*;

  // Last table entry is kept for the run after the flush
  localparam int n_entries      = 18;
  localparam int timeout_cycles = n_entries * 60;

  // DUT ports
  logic                  clk_i;
  logic                  rst_i;
  logic                  flush_i;
  logic [data_width-1:0] operand_a_i;
  logic [data_width-1:0] operand_b_i;
  op_e                   op_i;
  fmt_e                  fmt_i;
  logic [tag_width-1:0]  tag_i;
  logic                  in_valid_i;
  logic                  in_ready_o;
  logic [data_width-1:0] result_o;
  logic                  div_zero_o;
  logic [tag_width-1:0]  tag_o;
  logic                  out_valid_o;
  logic                  out_ready_i;
  logic                  busy_o;

  // Stimulus table with expected response per entry
  op_e                   tbl_op       [n_entries];
  fmt_e                  tbl_fmt      [n_entries];
  logic [data_width-1:0] tbl_a        [n_entries];
  logic [data_width-1:0] tbl_b        [n_entries];
  logic [tag_width-1:0]  tbl_tag      [n_entries];
  logic [data_width-1:0] exp_result   [n_entries];
  logic                  exp_div_zero [n_entries];

  logic [31:0] lcg_state;
  int          cycle_cnt = 0;

  divsqrt_unit i_dut (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .flush_i     ( flush_i     ),
    .operand_a_i ( operand_a_i ),
    .operand_b_i ( operand_b_i ),
    .op_i        ( op_i        ),
    .fmt_i       ( fmt_i       ),
    .tag_i       ( tag_i       ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .result_o    ( result_o    ),
    .div_zero_o  ( div_zero_o  ),
    .tag_o       ( tag_o       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .busy_o      ( busy_o      )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Run limit scaled by the table length
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped on timeout");
    end
  end

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------

  // Ones over the format width, the unused code counts as a full word
  function automatic logic [31:0] width_mask(fmt_e fmt);
    case (fmt)
      fmt_w8:  return 32'h0000_00ff;
      fmt_w16: return 32'h0000_ffff;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  // Largest root whose square does not exceed the value
  function automatic logic [31:0] floor_sqrt(logic [31:0] value);
    logic [31:0] root;
    logic [31:0] trial;
    int          b;
    root = '0;
    for (b = 15; b >= 0; b--) begin
      trial = root | (32'd1 << b);
      if (64'(trial) * 64'(trial) <= 64'(value)) begin
        root = trial;
      end
    end
    return root;
  endfunction

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic set_entry(input int idx, input op_e op, input fmt_e fmt,
                           input logic [31:0] a, input logic [31:0] b);
    logic [31:0] a_m;
    logic [31:0] b_m;
    a_m = a & width_mask(fmt);
    b_m = b & width_mask(fmt);
    tbl_op[idx]  = op;
    tbl_fmt[idx] = fmt;
    tbl_a[idx]   = a;
    tbl_b[idx]   = b;
    tbl_tag[idx] = 4'(idx * 5 + 3);
    exp_div_zero[idx] = (op == op_div) && (b_m == 0);
    if (exp_div_zero[idx]) begin
      exp_result[idx] = width_mask(fmt);
    end else if (op == op_div) begin
      exp_result[idx] = a_m / b_m;
    end else begin
      exp_result[idx] = floor_sqrt(a_m);
    end
  endtask

  task automatic build_table();
    set_entry(0,  op_div,  fmt_w8,  32'd200,       32'd7);
    // High garbage above the format is ignored
    set_entry(1,  op_div,  fmt_w8,  32'h1234_56ff, 32'hffff_ff10);
    set_entry(2,  op_div,  fmt_w16, 32'd50000,     32'd123);
    set_entry(3,  op_div,  fmt_w16, 32'hdead_0000, 32'd5);
    set_entry(4,  op_div,  fmt_w32, 32'hffff_ffff, 32'd1);
    set_entry(5,  op_div,  fmt_w32, 32'h8000_0001, 32'h0001_0000);
    set_entry(6,  op_div,  fmt_w32, 32'd1000,      32'd2000);
    // Divisor zero only after masking
    set_entry(7,  op_div,  fmt_w8,  32'd77,        32'h0000_0100);
    set_entry(8,  op_div,  fmt_w16, 32'd9,         32'd0);
    set_entry(9,  op_div,  fmt_w32, 32'd123,       32'd0);
    // Square root never flags a zero operand_b
    set_entry(10, op_sqrt, fmt_w8,  32'd255,       32'd0);
    set_entry(11, op_sqrt, fmt_w8,  32'h0000_1290, 32'd0);
    set_entry(12, op_sqrt, fmt_w16, 32'd65535,     32'd4);
    set_entry(13, op_sqrt, fmt_w16, 32'd10000,     32'd0);
    set_entry(14, op_sqrt, fmt_w32, 32'hffff_ffff, 32'd0);
    set_entry(15, op_sqrt, fmt_w32, 32'd2,         32'd0);
    set_entry(16, op_div,  fmt_e'(2'b11), 32'hffff_fffe, 32'h10);
    set_entry(17, op_div,  fmt_w16, 32'd40000,     32'd3);
  endtask

  // ----------------------------------------------------------------------
  // Checker, driver and monitor
  // ----------------------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // Ready seen mid-cycle means the transfer lands on the next edge
  task automatic wait_for_accept();
    @(negedge clk_i);
    while (!in_ready_o) begin
      @(negedge clk_i);
    end
  endtask

  task automatic send_entries(input int first, input int count);
    int idx;
    for (idx = first; idx < first + count; idx++) begin
      @(posedge clk_i);
      #2;
      operand_a_i = tbl_a[idx];
      operand_b_i = tbl_b[idx];
      op_i        = tbl_op[idx];
      fmt_i       = tbl_fmt[idx];
      tag_i       = tbl_tag[idx];
      in_valid_i  = 1'b1;
      wait_for_accept();
    end
    @(posedge clk_i);
    #2;
    in_valid_i = 1'b0;
  endtask

  // Takes results in table order, with random stalls on out_ready_i
  task automatic collect_results(input int first, input int count);
    int          idx;
    int          stall_left;
    int          parked_idx;
    logic        stalled;
    logic [31:0] rnd;
    logic [31:0] held_result;
    logic        held_div_zero;
    logic [3:0]  held_tag;
    idx        = first;
    stall_left = 0;
    parked_idx = -1;
    stalled    = 1'b0;
    while (idx < first + count) begin
      @(posedge clk_i);
      #2;
      rnd = next_random();
      // Every fourth result stays long enough for the next one to park in HOLD
      if (out_valid_o && (idx % 4 == 1) && (idx != parked_idx) &&
          (idx + 1 < first + count)) begin
        parked_idx = idx;
        stall_left = 36;
      end
      if (stall_left > 0) begin
        stall_left--;
        out_ready_i = 1'b0;
      end else begin
        out_ready_i = (rnd[18:16] > 3'd2);
      end
      @(negedge clk_i);
      // Stalled item must not move or change
      if (stalled) begin
        check_value("out_valid_o", out_valid_o, 1);
        check_value("result_o", result_o, held_result);
        check_value("div_zero_o", div_zero_o, held_div_zero);
        check_value("tag_o", tag_o, held_tag);
      end
      stalled = out_valid_o && !out_ready_i;
      held_result   = result_o;
      held_div_zero = div_zero_o;
      held_tag      = tag_o;
      if (out_valid_o && out_ready_i) begin
        check_value("tag_o", tag_o, tbl_tag[idx]);
        check_value("result_o", result_o, exp_result[idx]);
        check_value("div_zero_o", div_zero_o, exp_div_zero[idx]);
        idx++;
      end
    end
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      check_value("out_valid_o", out_valid_o, 0);
    end
  endtask

  // Two items in flight, one in the core and one in the input stage
  task automatic flush_in_flight();
    @(posedge clk_i);
    #2;
    out_ready_i = 1'b1;
    operand_a_i = 32'hfedc_ba98;
    operand_b_i = 32'd3;
    op_i        = op_div;
    fmt_i       = fmt_w32;
    tag_i       = 4'he;
    in_valid_i  = 1'b1;
    wait_for_accept();
    @(posedge clk_i);
    #2;
    operand_a_i = 32'h0000_ff00;
    op_i        = op_sqrt;
    tag_i       = 4'hd;
    wait_for_accept();
    @(posedge clk_i);
    #2;
    in_valid_i = 1'b0;
    repeat (6) @(posedge clk_i);
    @(negedge clk_i);
    check_value("busy_o", busy_o, 1);
    @(posedge clk_i);
    #2;
    flush_i = 1'b1;
    @(posedge clk_i);
    #2;
    flush_i = 1'b0;
    @(negedge clk_i);
    check_value("busy_o", busy_o, 0);
    // Long enough for the killed divide to have finished
    expect_quiet(40);
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    rst_i       = 1'b1;
    flush_i     = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    op_i        = op_div;
    fmt_i       = fmt_w8;
    tag_i       = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    lcg_state   = 32'hc40ffdb8;
    build_table();

    repeat (4) @(posedge clk_i);
    #2;
    rst_i = 1'b0;

    // Idle unit after reset
    @(negedge clk_i);
    check_value("out_valid_o", out_valid_o, 0);
    check_value("busy_o", busy_o, 0);
    check_value("in_ready_o", in_ready_o, 1);

    fork
      send_entries(0, n_entries - 1);
      collect_results(0, n_entries - 1);
    join

    // No duplicate may trail the last result
    expect_quiet(5);
    check_value("busy_o", busy_o, 0);

    flush_in_flight();

    fork
      send_entries(n_entries - 1, 1);
      collect_results(n_entries - 1, 1);
    join
    expect_quiet(3);
    check_value("busy_o", busy_o, 0);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: source/divsqrt_unit.sv
`timescale 1ns/1ps

module divsqrt_unit (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  input  logic                                   flush_i,
  // Request
  input  logic [divsqrt_cfg_pkg::data_width-1:0] operand_a_i,
  input  logic [divsqrt_cfg_pkg::data_width-1:0] operand_b_i,
  input  divsqrt_op_pkg::op_e                    op_i,
  input  divsqrt_op_pkg::fmt_e                   fmt_i,
  input  logic [divsqrt_cfg_pkg::tag_width-1:0]  tag_i,
  input  logic                                   in_valid_i,
  output logic                                   in_ready_o,
  // Response
  output logic [divsqrt_cfg_pkg::data_width-1:0] result_o,
  output logic                                   div_zero_o,
  output logic [divsqrt_cfg_pkg::tag_width-1:0]  tag_o,
  output logic                                   out_valid_o,
  input  logic                                   out_ready_i,
  output logic                                   busy_o
);

  import divsqrt_cfg_pkg::*;
  import divsqrt_op_pkg::*;

  // Input stage to control
  in_payload_t               in_data;
  logic                      in_valid;
  logic                      in_ready;
  // Decode results
  logic [data_width-1:0]     masked_a;
  logic [data_width-1:0]     masked_b;
  logic [iter_cnt_width-1:0] fmt_bits;
  logic                      is_div;
  logic                      dec_div_zero;
  // Control to core and result module
  logic                      start_div;
  logic                      start_sqrt;
  logic                      op_start;
  logic                      hold_en;
  logic                      ctrl_busy;
  // Core status
  logic                      core_ready;
  logic                      core_done;
  logic [data_width-1:0]     core_result;
  // Result module to output stage
  logic [data_width-1:0]     res_result;
  logic                      res_div_zero;
  logic [tag_width-1:0]      res_tag;
  logic                      out_valid;
  logic                      out_ready;

  // ----------------------------------------------------------------------
  // Input side
  // ----------------------------------------------------------------------

  divsqrt_pipe_reg #(
    .payload_t ( in_payload_t )
  ) i_in_stage (
    .clk_i   ( clk_i                                           ),
    .rst_i   ( rst_i                                           ),
    .flush_i ( flush_i                                         ),
    .valid_i ( in_valid_i                                      ),
    .ready_o ( in_ready_o                                      ),
    .data_i  ( in_payload_t'{operand_a: operand_a_i, operand_b: operand_b_i,
                             op: op_i, fmt: fmt_i, tag: tag_i} ),
    .valid_o ( in_valid                                        ),
    .ready_i ( in_ready                                        ),
    .data_o  ( in_data                                         )
  );

  divsqrt_decode i_decode (
    .operand_a_i ( in_data.operand_a ),
    .operand_b_i ( in_data.operand_b ),
    .op_i        ( in_data.op        ),
    .fmt_i       ( in_data.fmt       ),
    .masked_a_o  ( masked_a          ),
    .masked_b_o  ( masked_b          ),
    .fmt_bits_o  ( fmt_bits          ),
    .is_div_o    ( is_div            ),
    .div_zero_o  ( dec_div_zero      )
  );

  // ----------------------------------------------------------------------
  // Control and core
  // ----------------------------------------------------------------------

  divsqrt_ctrl i_ctrl (
    .clk_i        ( clk_i       ),
    .rst_i        ( rst_i       ),
    .flush_i      ( flush_i     ),
    .in_valid_i   ( in_valid    ),
    .in_ready_o   ( in_ready    ),
    .is_div_i     ( is_div      ),
    .start_div_o  ( start_div   ),
    .start_sqrt_o ( start_sqrt  ),
    .core_ready_i ( core_ready  ),
    .core_done_i  ( core_done   ),
    .op_start_o   ( op_start    ),
    .hold_en_o    ( hold_en     ),
    .out_valid_o  ( out_valid   ),
    .out_ready_i  ( out_ready   ),
    .busy_o       ( ctrl_busy   )
  );

  divsqrt_iter_core i_core (
    .clk_i        ( clk_i       ),
    .rst_i        ( rst_i       ),
    .kill_i       ( flush_i     ),
    .start_div_i  ( start_div   ),
    .start_sqrt_i ( start_sqrt  ),
    .operand_a_i  ( masked_a    ),
    .operand_b_i  ( masked_b    ),
    .iter_count_i ( fmt_bits    ),
    .core_ready_o ( core_ready  ),
    .core_done_o  ( core_done   ),
    .result_o     ( core_result )
  );

  // ----------------------------------------------------------------------
  // Output side
  // ----------------------------------------------------------------------

  divsqrt_result i_result (
    .clk_i         ( clk_i        ),
    .rst_i         ( rst_i        ),
    .op_start_i    ( op_start     ),
    .hold_en_i     ( hold_en      ),
    .use_held_i    ( ctrl_busy    ),
    .core_done_i   ( core_done    ),
    .core_result_i ( core_result  ),
    .tag_i         ( in_data.tag  ),
    .fmt_i         ( in_data.fmt  ),
    .div_zero_i    ( dec_div_zero ),
    .result_o      ( res_result   ),
    .div_zero_o    ( res_div_zero ),
    .tag_o         ( res_tag      )
  );

  divsqrt_pipe_reg #(
    .payload_t ( out_payload_t )
  ) i_out_stage (
    .clk_i   ( clk_i                                                  ),
    .rst_i   ( rst_i                                                  ),
    .flush_i ( flush_i                                                ),
    .valid_i ( out_valid                                              ),
    .ready_o ( out_ready                                              ),
    .data_i  ( out_payload_t'{result: res_result, div_zero: res_div_zero,
                              tag: res_tag}                           ),
    .valid_o ( out_valid_o                                            ),
    .ready_i ( out_ready_i                                            ),
    .data_o  ( {result_o, div_zero_o, tag_o}                          )
  );

  // Anything held in either stage or the core keeps the unit busy
  assign busy_o = in_valid | ctrl_busy | out_valid_o;

endmodule

// File: source/divsqrt_result.sv
`timescale 1ns/1ps

module divsqrt_result (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  input  logic                                   op_start_i,
  input  logic                                   hold_en_i,
  input  logic                                   use_held_i,
  input  logic                                   core_done_i,
  input  logic [divsqrt_cfg_pkg::data_width-1:0] core_result_i,
  input  logic [divsqrt_cfg_pkg::tag_width-1:0]  tag_i,
  input  divsqrt_op_pkg::fmt_e                   fmt_i,
  input  logic                                   div_zero_i,
  output logic [divsqrt_cfg_pkg::data_width-1:0] result_o,
  output logic                                   div_zero_o,
  output logic [divsqrt_cfg_pkg::tag_width-1:0]  tag_o
);

  import divsqrt_op_pkg::*;

  fmt_e                                   fmt_q;
  logic                                   div_zero_q;
  logic [divsqrt_cfg_pkg::tag_width-1:0]  tag_q;
  logic [divsqrt_cfg_pkg::data_width-1:0] held_q;
  logic [divsqrt_cfg_pkg::data_width-1:0] raw_result;

  // Side-band of the running operation, loaded when it starts
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fmt_q      <= fmt_w32;
      div_zero_q <= 1'b0;
      tag_q      <= '0;
    end else if (op_start_i) begin
      fmt_q      <= fmt_i;
      div_zero_q <= div_zero_i;
      tag_q      <= tag_i;
    end
  end

  // Hold register for a result the output stage could not take
  always_ff @(posedge clk_i) begin
    if (hold_en_i) begin
      held_q <= core_result_i;
    end
  end

  // ----------------------------------------------------------------------
  // Output select
  // ----------------------------------------------------------------------

  // Core value is live only in its done cycle, otherwise show the held copy
  assign raw_result = (use_held_i && !core_done_i) ? held_q : core_result_i;

  // Divide by zero reads as all ones of the format
  assign result_o   = div_zero_q ? fmt_mask(fmt_q) : raw_result;
  assign div_zero_o = div_zero_q;
  assign tag_o      = tag_q;

  // Core only finishes while the control still counts the unit busy
  a_done_while_busy: assert property (
    @(posedge clk_i) disable iff (rst_i)
    core_done_i |-> use_held_i
  ) else $error("core done outside a busy control");

endmodule

// File: source/divsqrt_iter_core.sv
`timescale 1ns/1ps

module divsqrt_iter_core (
  input  logic                                       clk_i,
  input  logic                                       rst_i,
  input  logic                                       kill_i,
  input  logic                                       start_div_i,
  input  logic                                       start_sqrt_i,
  input  logic [divsqrt_cfg_pkg::data_width-1:0]     operand_a_i,
  input  logic [divsqrt_cfg_pkg::data_width-1:0]     operand_b_i,
  input  logic [divsqrt_cfg_pkg::iter_cnt_width-1:0] iter_count_i,
  output logic                                       core_ready_o,
  output logic                                       core_done_o,
  output logic [divsqrt_cfg_pkg::data_width-1:0]     result_o
);

  import divsqrt_cfg_pkg::*;

  // Control state
  logic                      busy_q;
  logic                      is_sqrt_q;
  logic [iter_cnt_width-1:0] cnt_q;
  // Datapath registers
  logic [data_width-1:0]     rem_q;
  logic [data_width-1:0]     quo_q;
  logic [data_width-1:0]     src_q;
  logic [data_width-1:0]     dvs_q;
  // One step of the recurrence
  logic [data_width:0]       trial;
  logic [data_width:0]       subtrahend;
  logic [data_width:0]       diff;
  logic                      bit_set;
  logic [data_width-1:0]     rem_d;
  logic [data_width-1:0]     quo_d;
  logic [data_width-1:0]     src_d;
  // Start decode
  logic                      start;
  logic [iter_cnt_width-1:0] load_cnt;
  logic [iter_cnt_width-1:0] align;

  // ----------------------------------------------------------------------
  // Shared restoring step
  // ----------------------------------------------------------------------

  always_comb begin
    if (is_sqrt_q) begin
      // Bring down the next radicand bit pair, test against 4*root + 1
      trial      = {1'b0, rem_q[data_width-3:0], src_q[data_width-1 -: 2]};
      subtrahend = {1'b0, quo_q[data_width-3:0], 2'b01};
      src_d      = {src_q[data_width-3:0], 2'b00};
    end else begin
      // Bring down the next dividend bit, test against the divisor
      trial      = {rem_q, src_q[data_width-1]};
      subtrahend = {1'b0, dvs_q};
      src_d      = {src_q[data_width-2:0], 1'b0};
    end
    diff    = trial - subtrahend;
    bit_set = (trial >= subtrahend);
    // Restore on a failed trial, remainder always fits one word
    rem_d   = bit_set ? diff[data_width-1:0] : trial[data_width-1:0];
    quo_d   = {quo_q[data_width-2:0], bit_set};
  end

  // ----------------------------------------------------------------------
  // Sequencing
  // ----------------------------------------------------------------------

  assign start    = start_div_i | start_sqrt_i;
  // Square root retires two bits per step
  assign load_cnt = start_sqrt_i ? (iter_count_i >> 1) : iter_count_i;
  // Left-align the format so its MSB feeds the first step
  assign align    = iter_cnt_width'(data_width) - iter_count_i;

  always_ff @(posedge clk_i) begin
    if (rst_i || kill_i) begin
      busy_q    <= 1'b0;
      is_sqrt_q <= 1'b0;
      cnt_q     <= '0;
    end else if (start) begin
      busy_q    <= 1'b1;
      is_sqrt_q <= start_sqrt_i;
      cnt_q     <= load_cnt;
    end else if (busy_q) begin
      cnt_q <= cnt_q - 1'b1;
      if (cnt_q == iter_cnt_width'(1)) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      rem_q <= '0;
      quo_q <= '0;
      src_q <= operand_a_i << align;
      dvs_q <= operand_b_i;
    end else if (busy_q) begin
      rem_q <= rem_d;
      quo_q <= quo_d;
      src_q <= src_d;
    end
  end

  // Last step is taken combinationally, so done lands count cycles after start
  assign core_done_o  = busy_q & (cnt_q == iter_cnt_width'(1)) & ~kill_i;
  // Ready again in the done cycle for back-to-back operation
  assign core_ready_o = ~busy_q | core_done_o;
  assign result_o     = quo_d;

  a_one_start: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(start_div_i && start_sqrt_i)
  ) else $error("divide and sqrt started together");

endmodule

// File: source/divsqrt_ctrl.sv
`timescale 1ns/1ps

module divsqrt_ctrl (
  input  logic clk_i,
  input  logic rst_i,
  input  logic flush_i,
  // Input stage handshake
  input  logic in_valid_i,
  output logic in_ready_o,
  input  logic is_div_i,
  // Core interface
  output logic start_div_o,
  output logic start_sqrt_o,
  input  logic core_ready_i,
  input  logic core_done_i,
  // Result module strobes
  output logic op_start_o,
  output logic hold_en_o,
  // Output stage handshake
  output logic out_valid_o,
  input  logic out_ready_i,
  output logic busy_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_busy,
    st_hold
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   in_ready;
  logic   start;

  // ----------------------------------------------------------------------
  // Next state and handshakes
  // ----------------------------------------------------------------------

  always_comb begin
    state_d     = state_q;
    in_ready    = 1'b0;
    out_valid_o = 1'b0;
    hold_en_o   = 1'b0;
    busy_o      = 1'b0;

    unique case (state_q)
      // Nothing in the core
      st_idle: begin
        in_ready = 1'b1;
        if (in_valid_i) begin
          state_d = st_busy;
        end
      end
      // Core iterating
      st_busy: begin
        busy_o = 1'b1;
        if (core_done_i) begin
          out_valid_o = 1'b1;
          if (out_ready_i) begin
            // Result leaves now, next operation may start in this cycle
            in_ready = core_ready_i;
            state_d  = (in_valid_i && core_ready_i) ? st_busy : st_idle;
          end else begin
            // Downstream stalled, keep the result in the result module
            hold_en_o = 1'b1;
            state_d   = st_hold;
          end
        end
      end
      // Result parked, waiting for the output stage
      st_hold: begin
        busy_o      = 1'b1;
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          in_ready = core_ready_i;
          state_d  = (in_valid_i && core_ready_i) ? st_busy : st_idle;
        end
      end
      default: state_d = st_idle;
    endcase

    // Flush drops everything in flight
    if (flush_i) begin
      out_valid_o = 1'b0;
      hold_en_o   = 1'b0;
      busy_o      = 1'b0;
      state_d     = st_idle;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------------------------------------
  // Core start
  // ----------------------------------------------------------------------

  // Start coincides with the input transfer
  assign start        = in_valid_i & in_ready & ~flush_i;
  assign start_div_o  = start & is_div_i;
  assign start_sqrt_o = start & ~is_div_i;
  assign op_start_o   = start;
  assign in_ready_o   = in_ready;

  // Idle control implies an idle core, including after a kill
  a_start_core_ready: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (start_div_o || start_sqrt_o) |-> core_ready_i
  ) else $error("core started while not ready");

endmodule

// File: source/divsqrt_decode.sv
`timescale 1ns/1ps

module divsqrt_decode (
  input  logic [divsqrt_cfg_pkg::data_width-1:0]     operand_a_i,
  input  logic [divsqrt_cfg_pkg::data_width-1:0]     operand_b_i,
  input  divsqrt_op_pkg::op_e                        op_i,
  input  divsqrt_op_pkg::fmt_e                       fmt_i,
  output logic [divsqrt_cfg_pkg::data_width-1:0]     masked_a_o,
  output logic [divsqrt_cfg_pkg::data_width-1:0]     masked_b_o,
  output logic [divsqrt_cfg_pkg::iter_cnt_width-1:0] fmt_bits_o,
  output logic                                       is_div_o,
  output logic                                       div_zero_o
);

  import divsqrt_op_pkg::*;

  logic [divsqrt_cfg_pkg::data_width-1:0] mask;

  // ----------------------------------------------------------------------
  // Format mapping
  // ----------------------------------------------------------------------

  // Narrow formats sit in the low bits, upper bits are ignored
  assign mask       = fmt_mask(fmt_i);
  assign masked_a_o = operand_a_i & mask;
  assign masked_b_o = operand_b_i & mask;

  // Width of the format, the core derives its step count from it
  assign fmt_bits_o = fmt_width(fmt_i);

  // ----------------------------------------------------------------------
  // Operation class
  // ----------------------------------------------------------------------

  assign is_div_o = (op_i == op_div);

  // Zero divisor seen after masking, so high garbage does not hide it
  assign div_zero_o = is_div_o & ~|masked_b_o;

endmodule

// File: source/divsqrt_pipe_reg.sv
`timescale 1ns/1ps

module divsqrt_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     flush_i,
  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Advance when downstream takes the item or the slot only holds a bubble
  assign ready_o = ready_i | ~valid_q;

  // Valid flag, flush wins over any incoming item
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload only moves on a real transfer
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

  // Stalled item must stay put until taken, unless flushed
  a_stall_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (valid_o && !ready_i && !flush_i) |=> (valid_o && $stable(data_o))
  ) else $error("pipe stage changed a stalled item");

endmodule

// File: source/divsqrt_op_pkg.sv
package divsqrt_op_pkg;

  // Operation select
  typedef enum logic {
    op_div  = 1'b0,
    op_sqrt = 1'b1
  } op_e;

  // Operand format, code 2'b11 is illegal and runs as fmt_w32
  typedef enum logic [1:0] {
    fmt_w8  = 2'b00,
    fmt_w16 = 2'b01,
    fmt_w32 = 2'b10
  } fmt_e;

  // Item held by the input stage
  typedef struct packed {
    logic [divsqrt_cfg_pkg::data_width-1:0] operand_a;
    logic [divsqrt_cfg_pkg::data_width-1:0] operand_b;
    op_e                                    op;
    fmt_e                                   fmt;
    logic [divsqrt_cfg_pkg::tag_width-1:0]  tag;
  } in_payload_t;

  // Item held by the output stage
  typedef struct packed {
    logic [divsqrt_cfg_pkg::data_width-1:0] result;
    logic                                   div_zero;
    logic [divsqrt_cfg_pkg::tag_width-1:0]  tag;
  } out_payload_t;

  // Bit width of a format, unknown codes fall back to the full word
  function automatic logic [divsqrt_cfg_pkg::iter_cnt_width-1:0] fmt_width(fmt_e fmt);
    case (fmt)
      fmt_w8:  return divsqrt_cfg_pkg::iter_cnt_width'(divsqrt_cfg_pkg::fmt_width_w8);
      fmt_w16: return divsqrt_cfg_pkg::iter_cnt_width'(divsqrt_cfg_pkg::fmt_width_w16);
      default: return divsqrt_cfg_pkg::iter_cnt_width'(divsqrt_cfg_pkg::fmt_width_w32);
    endcase
  endfunction

  // Ones in the low fmt_width bits of the word
  function automatic logic [divsqrt_cfg_pkg::data_width-1:0] fmt_mask(fmt_e fmt);
    return {divsqrt_cfg_pkg::data_width{1'b1}}
           >> (divsqrt_cfg_pkg::data_width - fmt_width(fmt));
  endfunction

endpackage

// File: source/divsqrt_cfg_pkg.sv
package divsqrt_cfg_pkg;

  // ----------------------------------------------------------------------
  // Datapath sizes
  // ----------------------------------------------------------------------

  // Operand and result word
  localparam int unsigned data_width = 32;

  // User tag that follows each operation through the unit
  localparam int unsigned tag_width = 4;

  // Counter has to reach data_width itself for a full-word divide
  localparam int unsigned iter_cnt_width = $clog2(data_width + 1);

  // ----------------------------------------------------------------------
  // Operand formats
  // ----------------------------------------------------------------------

  // Bit widths of the three supported formats
  localparam int unsigned fmt_width_w8  = 8;
  localparam int unsigned fmt_width_w16 = 16;
  localparam int unsigned fmt_width_w32 = 32;

endpackage
